//--- Bender.yml
package:
  name: control_unit

sources:
  - hw/controlPkg.sv
  - hw/instrDecoder.sv
  - hw/controlSequencer.sv
  - hw/controlWordReg.sv
  - hw/controlUnit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/controlUnitTb.sv

//--- hw/controlPkg.sv
package controlPkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    localparam opcode_t opRFormat = 6'h00;
    localparam opcode_t opJ       = 6'h02;
    localparam opcode_t opJal     = 6'h03;
    localparam opcode_t opBeq     = 6'h04;
    localparam opcode_t opBne     = 6'h05;
    localparam opcode_t opBle     = 6'h06;
    localparam opcode_t opBgt     = 6'h07;
    localparam opcode_t opAddi    = 6'h08;
    localparam opcode_t opAddiu   = 6'h09;
    localparam opcode_t opSlti    = 6'h0A;
    localparam opcode_t opLui     = 6'h0F;
    localparam opcode_t opLb      = 6'h20;
    localparam opcode_t opLh      = 6'h21;
    localparam opcode_t opLw      = 6'h23;
    localparam opcode_t opSb      = 6'h28;
    localparam opcode_t opSh      = 6'h29;
    localparam opcode_t opSw      = 6'h2B;

    localparam funct_t fnJr  = 6'h08;
    localparam funct_t fnAdd = 6'h20;
    localparam funct_t fnSub = 6'h22;
    localparam funct_t fnAnd = 6'h24;
    localparam funct_t fnSlt = 6'h2A;

    typedef logic [2:0] aluOp_t;
    localparam aluOp_t aluPass    = 3'd0;
    localparam aluOp_t aluAdd     = 3'd1;
    localparam aluOp_t aluSub     = 3'd2;
    localparam aluOp_t aluAnd     = 3'd3;
    localparam aluOp_t aluCompare = 3'd7;

    // Operand A and operand B share one field type
    typedef logic [1:0] aluSrc_t;
    localparam aluSrc_t srcAPc         = 2'd0;
    localparam aluSrc_t srcARegA       = 2'd1;
    localparam aluSrc_t srcBRegB       = 2'd0;
    localparam aluSrc_t srcBFour       = 2'd1;
    localparam aluSrc_t srcBImm        = 2'd2;
    localparam aluSrc_t srcBImmShifted = 2'd3;

    typedef logic [2:0] pcSource_t;
    localparam pcSource_t pcFromException = 3'd0;
    localparam pcSource_t pcFromAlu       = 3'd1;
    localparam pcSource_t pcFromAluOut    = 3'd2;
    localparam pcSource_t pcFromJump      = 3'd3;

    typedef logic [2:0] regDst_t;
    localparam regDst_t dstRt = 3'd0;
    localparam regDst_t dstRd = 3'd1;
    localparam regDst_t dstRa = 3'd3;

    typedef logic [3:0] memToReg_t;
    localparam memToReg_t wbAluOut   = 4'd0;
    localparam memToReg_t wbMemData  = 4'd1;
    localparam memToReg_t wbCompare  = 4'd4;
    localparam memToReg_t wbUpperImm = 4'd6;

    typedef logic [2:0] memAddrSel_t;
    localparam memAddrSel_t addrPc             = 3'd0;
    localparam memAddrSel_t addrAluOut         = 3'd2;
    localparam memAddrSel_t addrInvalidVector  = 3'd3;
    localparam memAddrSel_t addrOverflowVector = 3'd4;

    typedef logic [1:0] accessSize_t;
    localparam accessSize_t sizeNone = 2'd0;
    localparam accessSize_t sizeWord = 2'd1;
    localparam accessSize_t sizeHalf = 2'd2;
    localparam accessSize_t sizeByte = 2'd3;

    typedef enum logic [4:0] {
        clsAdd, clsSub, clsAnd, clsSlt, clsJr,
        clsAddi, clsAddiu, clsSlti, clsLui,
        clsBeq, clsBne, clsBle, clsBgt,
        clsLw, clsLh, clsLb, clsSw, clsSh, clsSb,
        clsJ, clsJal, clsInvalid
    } instrClass_t;

    // One register update per cycle, applied by controlWordReg
    typedef enum logic [5:0] {
        actHold, actFetchInc, actPcLoad, actIrLoad, actTargetCalc, actRegLoad,
        actAluRegAdd, actAluRegSub, actAluRegAnd, actAluImm,
        actWriteRd, actWriteRt, actCompareRd, actCompareRt, actUpperImm,
        actBranchCompare, actBranchTaken, actJump, actJalSave, actJalLink, actJalJump,
        actJrJump, actMemAddr,
        actStoreWord, actStoreHalf, actStoreByte, actLoadWord, actLoadHalf, actLoadByte,
        actExcSave, actExcVecOverflow, actExcVecInvalid, actExcJump, actClose
    } ctrlAction_t;

endpackage

//--- hw/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer #(
    parameter int unsigned memWaitCycles = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  controlPkg::instrClass_t instrClass,
    input  logic                    overflow,
    input  logic                    equal,
    input  logic                    greater,
    output controlPkg::ctrlAction_t action
);
    import controlPkg::*;

    typedef enum logic [3:0] {
        fetch, decode, execute, aluWrite, immWrite, branchResolve, jalLink, jalJump,
        memAddr, memWait, memAccess, exceptionSave, exceptionVector, exceptionWait,
        exceptionJump, closeWrite
    } seqState_t;

    // Counter also steps the three fetch and two decode cycles
    localparam int unsigned stepMax = (memWaitCycles > 3) ? memWaitCycles : 3;
    typedef logic [$clog2(stepMax)-1:0] step_t;

    localparam step_t lastFetch  = step_t'(2);
    localparam step_t lastDecode = step_t'(1);
    localparam step_t lastWait   = step_t'(memWaitCycles - 1);

    seqState_t state;
    seqState_t nextState;
    step_t     stepCount;
    logic      overflowTrap;
    logic      branchTaken;

    assign overflowTrap = overflow &&
        (instrClass == clsAdd || instrClass == clsSub || instrClass == clsAddi);

    assign branchTaken = (instrClass == clsBeq && equal) ||
                         (instrClass == clsBne && !equal) ||
                         (instrClass == clsBle && !greater) ||
                         (instrClass == clsBgt && greater);

    always_comb begin
        nextState = state;
        action    = actHold;
        case (state)
            fetch: begin
                case (stepCount)
                    step_t'(0): action = actFetchInc;
                    step_t'(1): action = actPcLoad;
                    default:    action = actIrLoad;
                endcase
                if (stepCount == lastFetch) nextState = decode;
            end
            decode: begin
                action = (stepCount == lastDecode) ? actRegLoad : actTargetCalc;
                if (stepCount == lastDecode) nextState = execute;
            end
            execute: begin
                nextState = closeWrite; // Single-step instructions
                case (instrClass)
                    clsAdd, clsSub, clsAnd: begin
                        action    = (instrClass == clsAdd) ? actAluRegAdd :
                                    (instrClass == clsSub) ? actAluRegSub : actAluRegAnd;
                        nextState = aluWrite;
                    end
                    clsSlt:  action = actCompareRd;
                    clsJr:   action = actJrJump;
                    clsSlti: action = actCompareRt;
                    clsLui:  action = actUpperImm;
                    clsJ:    action = actJump;
                    clsAddi, clsAddiu: begin
                        action    = actAluImm;
                        nextState = immWrite;
                    end
                    clsBeq, clsBne, clsBle, clsBgt: begin
                        action    = actBranchCompare;
                        nextState = branchResolve;
                    end
                    clsLw, clsLh, clsLb, clsSw, clsSh, clsSb: begin
                        action    = actAluImm; // Effective address
                        nextState = memAddr;
                    end
                    clsJal: begin
                        action    = actJalSave;
                        nextState = jalLink;
                    end
                    default: nextState = exceptionSave;
                endcase
            end
            aluWrite: begin
                action    = overflowTrap ? actHold : actWriteRd;
                nextState = overflowTrap ? exceptionSave : closeWrite;
            end
            immWrite: begin
                action    = overflowTrap ? actHold : actWriteRt;
                nextState = overflowTrap ? exceptionSave : closeWrite;
            end
            branchResolve: begin
                action    = branchTaken ? actBranchTaken : actHold;
                nextState = closeWrite;
            end
            jalLink: begin
                action    = actJalLink;
                nextState = jalJump;
            end
            jalJump: begin
                action    = actJalJump;
                nextState = closeWrite;
            end
            memAddr: begin
                action    = actMemAddr;
                nextState = (memWaitCycles > 0) ? memWait : memAccess;
            end
            memWait: if (stepCount == lastWait) nextState = memAccess;
            memAccess: begin
                case (instrClass)
                    clsSw:   action = actStoreWord;
                    clsSh:   action = actStoreHalf;
                    clsSb:   action = actStoreByte;
                    clsLw:   action = actLoadWord;
                    clsLh:   action = actLoadHalf;
                    default: action = actLoadByte;
                endcase
                nextState = closeWrite;
            end
            exceptionSave: begin
                action    = actExcSave;
                nextState = exceptionVector;
            end
            exceptionVector: begin
                action    = (instrClass == clsInvalid) ? actExcVecInvalid : actExcVecOverflow;
                nextState = (memWaitCycles > 0) ? exceptionWait : exceptionJump;
            end
            exceptionWait: if (stepCount == lastWait) nextState = exceptionJump;
            exceptionJump: begin
                action    = actExcJump;
                nextState = closeWrite;
            end
            default: begin
                action    = actClose;
                nextState = fetch;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= fetch;
            stepCount <= '0;
        end else begin
            state     <= nextState;
            stepCount <= (nextState != state) ? '0 : stepCount + step_t'(1);
        end
    end

endmodule

//--- hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
    parameter int unsigned memWaitCycles = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  controlPkg::opcode_t     opcode,
    input  controlPkg::funct_t      funct,
    input  logic                    overflow,
    input  logic                    equal,
    input  logic                    greater,
    output logic                    memWrite,
    output logic                    pcWrite,
    output logic                    irWrite,
    output logic                    regWrite,
    output logic                    abWrite,
    output logic                    aluOutWrite,
    output logic                    epcWrite,
    output controlPkg::aluOp_t      aluOp,
    output controlPkg::aluSrc_t     aluSrcA,
    output controlPkg::aluSrc_t     aluSrcB,
    output controlPkg::pcSource_t   pcSource,
    output controlPkg::regDst_t     regDst,
    output controlPkg::memToReg_t   memToReg,
    output controlPkg::memAddrSel_t memAddrSel,
    output controlPkg::accessSize_t storeSize,
    output controlPkg::accessSize_t loadSize
);
    import controlPkg::*;

    instrClass_t instrClass;
    ctrlAction_t action;

    instrDecoder decoder (
        .opcode    (opcode),
        .funct     (funct),
        .instrClass(instrClass)
    );

    controlSequencer #(
        .memWaitCycles(memWaitCycles)
    ) sequencer (
        .clk       (clk),
        .reset     (reset),
        .instrClass(instrClass),
        .overflow  (overflow),
        .equal     (equal),
        .greater   (greater),
        .action    (action)
    );

    controlWordReg wordReg (
        .clk        (clk),
        .reset      (reset),
        .action     (action),
        .memWrite   (memWrite),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .abWrite    (abWrite),
        .aluOutWrite(aluOutWrite),
        .epcWrite   (epcWrite),
        .aluOp      (aluOp),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .pcSource   (pcSource),
        .regDst     (regDst),
        .memToReg   (memToReg),
        .memAddrSel (memAddrSel),
        .storeSize  (storeSize),
        .loadSize   (loadSize)
    );

endmodule

//--- hw/controlWordReg.sv
`timescale 1ns/1ps

module controlWordReg (
    input  logic                    clk,
    input  logic                    reset,
    input  controlPkg::ctrlAction_t action,
    output logic                    memWrite,
    output logic                    pcWrite,
    output logic                    irWrite,
    output logic                    regWrite,
    output logic                    abWrite,
    output logic                    aluOutWrite,
    output logic                    epcWrite,
    output controlPkg::aluOp_t      aluOp,
    output controlPkg::aluSrc_t     aluSrcA,
    output controlPkg::aluSrc_t     aluSrcB,
    output controlPkg::pcSource_t   pcSource,
    output controlPkg::regDst_t     regDst,
    output controlPkg::memToReg_t   memToReg,
    output controlPkg::memAddrSel_t memAddrSel,
    output controlPkg::accessSize_t storeSize,
    output controlPkg::accessSize_t loadSize
);
    import controlPkg::*;

    function automatic accessSize_t sizeOf(input ctrlAction_t act);
        case (act)
            actStoreWord, actLoadWord: sizeOf = sizeWord;
            actStoreHalf, actLoadHalf: sizeOf = sizeHalf;
            actStoreByte, actLoadByte: sizeOf = sizeByte;
            default:                   sizeOf = sizeNone;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset || action == actClose) begin
            {memWrite, pcWrite, irWrite, regWrite} <= '0;
            {abWrite, aluOutWrite, epcWrite} <= '0;
            aluOp      <= aluPass;
            aluSrcA    <= srcAPc;
            aluSrcB    <= srcBRegB;
            pcSource   <= pcFromException;
            regDst     <= dstRt;
            memToReg   <= wbAluOut;
            memAddrSel <= addrPc;
            storeSize  <= sizeNone;
            loadSize   <= sizeNone;
        end else begin
            // Write strobes last one cycle
            {memWrite, pcWrite, irWrite, regWrite, epcWrite} <= '0;
            case (action)
                actFetchInc: begin
                    aluSrcA    <= srcAPc;
                    aluSrcB    <= srcBFour;
                    aluOp      <= aluAdd;
                    memAddrSel <= addrPc;
                end
                actPcLoad: begin
                    pcSource <= pcFromAlu;
                    pcWrite  <= 1'b1;
                end
                actIrLoad: irWrite <= 1'b1;
                actTargetCalc: begin
                    aluSrcB     <= srcBImmShifted; // Branch target into aluOut
                    aluOutWrite <= 1'b1;
                end
                actRegLoad: begin
                    abWrite     <= 1'b1;
                    aluOutWrite <= 1'b0;
                end
                actAluRegAdd, actAluRegSub, actAluRegAnd, actAluImm: begin
                    aluSrcA     <= srcARegA;
                    aluSrcB     <= (action == actAluImm) ? srcBImm : srcBRegB;
                    aluOp       <= (action == actAluRegSub) ? aluSub :
                                   (action == actAluRegAnd) ? aluAnd : aluAdd;
                    aluOutWrite <= 1'b1;
                    abWrite     <= 1'b0;
                end
                actWriteRd, actWriteRt, actJalLink: begin
                    regDst      <= (action == actWriteRd) ? dstRd :
                                   (action == actJalLink) ? dstRa : dstRt;
                    memToReg    <= wbAluOut;
                    regWrite    <= 1'b1;
                    aluOutWrite <= 1'b0;
                end
                actCompareRd, actCompareRt, actBranchCompare: begin
                    aluSrcA  <= srcARegA;
                    aluSrcB  <= (action == actCompareRt) ? srcBImm : srcBRegB;
                    aluOp    <= aluCompare;
                    abWrite  <= 1'b0;
                    regDst   <= (action == actCompareRd) ? dstRd : dstRt;
                    memToReg <= wbCompare;
                    regWrite <= (action != actBranchCompare);
                end
                actUpperImm: begin
                    regDst   <= dstRt;
                    memToReg <= wbUpperImm;
                    regWrite <= 1'b1;
                    abWrite  <= 1'b0;
                end
                actBranchTaken: begin
                    pcSource <= pcFromAluOut;
                    pcWrite  <= 1'b1;
                end
                actJump, actJalJump: begin
                    pcSource <= pcFromJump;
                    pcWrite  <= 1'b1;
                    abWrite  <= 1'b0;
                end
                actJalSave: begin
                    aluSrcA     <= srcAPc; // Return address through aluOut
                    aluOp       <= aluPass;
                    aluOutWrite <= 1'b1;
                    abWrite     <= 1'b0;
                end
                actJrJump: begin
                    aluSrcA  <= srcARegA;
                    aluOp    <= aluPass;
                    pcSource <= pcFromAlu;
                    pcWrite  <= 1'b1;
                    abWrite  <= 1'b0;
                end
                actMemAddr: begin
                    memAddrSel  <= addrAluOut;
                    aluOutWrite <= 1'b0;
                end
                actStoreWord, actStoreHalf, actStoreByte: begin
                    storeSize <= sizeOf(action);
                    memWrite  <= 1'b1;
                end
                actLoadWord, actLoadHalf, actLoadByte: begin
                    loadSize <= sizeOf(action);
                    regDst   <= dstRt;
                    memToReg <= wbMemData;
                    regWrite <= 1'b1;
                end
                actExcSave: begin
                    aluSrcA     <= srcAPc; // EPC gets PC minus four
                    aluSrcB     <= srcBFour;
                    aluOp       <= aluSub;
                    epcWrite    <= 1'b1;
                    abWrite     <= 1'b0;
                    aluOutWrite <= 1'b0;
                end
                actExcVecOverflow: memAddrSel <= addrOverflowVector;
                actExcVecInvalid:  memAddrSel <= addrInvalidVector;
                actExcJump: begin
                    pcSource <= pcFromException;
                    pcWrite  <= 1'b1;
                    loadSize <= sizeByte; // Handler address byte
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  controlPkg::opcode_t     opcode,
    input  controlPkg::funct_t      funct,
    output controlPkg::instrClass_t instrClass
);
    import controlPkg::*;

    always_comb begin
        instrClass = clsInvalid; // Anything not listed traps
        case (opcode)
            opRFormat: begin
                case (funct)
                    fnAdd:   instrClass = clsAdd;
                    fnSub:   instrClass = clsSub;
                    fnAnd:   instrClass = clsAnd;
                    fnSlt:   instrClass = clsSlt;
                    fnJr:    instrClass = clsJr;
                    default: instrClass = clsInvalid;
                endcase
            end
            opAddi:  instrClass = clsAddi;
            opAddiu: instrClass = clsAddiu;
            opSlti:  instrClass = clsSlti;
            opLui:   instrClass = clsLui;
            opBeq:   instrClass = clsBeq;
            opBne:   instrClass = clsBne;
            opBle:   instrClass = clsBle;
            opBgt:   instrClass = clsBgt;
            opLw:    instrClass = clsLw;
            opLh:    instrClass = clsLh;
            opLb:    instrClass = clsLb;
            opSw:    instrClass = clsSw;
            opSh:    instrClass = clsSh;
            opSb:    instrClass = clsSb;
            opJ:     instrClass = clsJ;
            opJal:   instrClass = clsJal;
            default: instrClass = clsInvalid;
        endcase
    end

endmodule

//--- sim.f
+incdir+include
hw/controlPkg.sv
hw/instrDecoder.sv
hw/controlSequencer.sv
hw/controlWordReg.sv
hw/controlUnit.sv
tb/controlUnitTb.sv

//--- include/controlTbTasks.svh
localparam funct_t noFunct = funct_t'(0);

// Seen during the last instruction
int          cycles;
int          regPulses;
int          pcPulses;
int          memPulses;
int          epcPulses;
int          firstRegCycle;
int          firstPcCycle;
regDst_t     wrDst;
memToReg_t   wrSrc;
aluOp_t      wrOp;
accessSize_t wrLoad;
accessSize_t stSize;
pcSource_t   jumpSrc;
memAddrSel_t jumpAddr;
accessSize_t jumpLoad;

task automatic driveInputs(input opcode_t op, input funct_t fn, input logic ovf,
                           input logic eq, input logic gt);
    opcode   = op;
    funct    = fn;
    overflow = ovf;
    equal    = eq;
    greater  = gt;
endtask

task automatic reportProblem(input string msg);
    otherErrors++;
    $display("%s", msg);
endtask

task automatic reportCompare(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
        valueErrors++;
        $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic checkEnable(input string name, input logic exp, input logic act);
    reportCompare(name, exp, act);
endtask

task automatic checkAluOp(input string name, input aluOp_t exp, input aluOp_t act);
    reportCompare(name, exp, act);
endtask

task automatic checkAluSrc(input string name, input aluSrc_t exp, input aluSrc_t act);
    reportCompare(name, exp, act);
endtask

task automatic checkPcSource(input string name, input pcSource_t exp, input pcSource_t act);
    reportCompare(name, exp, act);
endtask

task automatic checkRegDst(input string name, input regDst_t exp, input regDst_t act);
    reportCompare(name, exp, act);
endtask

task automatic checkMemToReg(input string name, input memToReg_t exp, input memToReg_t act);
    reportCompare(name, exp, act);
endtask

task automatic checkAddrSel(input string name, input memAddrSel_t exp,
                            input memAddrSel_t act);
    reportCompare(name, exp, act);
endtask

task automatic checkSize(input string name, input accessSize_t exp, input accessSize_t act);
    reportCompare(name, exp, act);
endtask

task automatic checkLength(input string name, input int exp, input int act);
    reportCompare(name, exp, act);
endtask

task automatic checkCount(input string name, input int exp, input int act);
    reportCompare(name, exp, act);
endtask

function automatic logic branchHolds(input opcode_t op, input logic eq, input logic gt);
    case (op)
        opBeq:   return eq;
        opBne:   return !eq;
        opBle:   return !gt;
        default: return gt;
    endcase
endfunction

// Starts in an irWrite cycle, runs to the next irWrite
task automatic runInstr(input string name, input opcode_t op, input funct_t fn,
                        input logic ovf, input logic eq, input logic gt);
    logic [4:0] strobes;
    logic [4:0] prevStrobes;
    driveInputs(op, fn, ovf, eq, gt);
    cycles    = 0;
    regPulses = 0;
    pcPulses  = 0;
    memPulses = 0;
    epcPulses = 0;
    prevStrobes = {regWrite, pcWrite, memWrite, epcWrite, irWrite};
    do begin
        @(posedge clk);
        #1;
        cycles++;
        strobes = {regWrite, pcWrite, memWrite, epcWrite, irWrite};
        if ((strobes & prevStrobes) != 0)
            reportProblem({name, ": a write strobe stayed high for two cycles"});
        prevStrobes = strobes;
        if (regWrite) begin
            if (regPulses == 0) begin
                firstRegCycle = cycles;
                wrDst  = regDst;
                wrSrc  = memToReg;
                wrOp   = aluOp;
                wrLoad = loadSize;
            end
            regPulses++;
        end
        if (pcWrite) begin
            if (pcPulses == 0) begin
                firstPcCycle = cycles;
                jumpSrc  = pcSource;
                jumpAddr = memAddrSel;
                jumpLoad = loadSize;
            end
            pcPulses++;
        end
        if (memWrite) begin
            stSize = storeSize;
            memPulses++;
        end
        if (epcWrite) epcPulses++;
    end while (!irWrite && cycles < cycleLimit);
    if (!irWrite) reportProblem({name, ": the next instruction fetch never came"});
endtask

task automatic testResetFetch();
    int waited;
    repeat (5) begin
        @(posedge clk);
        #1;
        checkEnable("reset enables", 1'b0,
                    |{memWrite, pcWrite, irWrite, regWrite, abWrite, aluOutWrite, epcWrite});
    end
    checkAluOp("reset aluOp", aluOp_t'(0), aluOp);
    checkAluSrc("reset aluSrcA", aluSrc_t'(0), aluSrcA);
    checkAluSrc("reset aluSrcB", aluSrc_t'(0), aluSrcB);
    checkPcSource("reset pcSource", pcSource_t'(0), pcSource);
    checkRegDst("reset regDst", regDst_t'(0), regDst);
    checkMemToReg("reset memToReg", memToReg_t'(0), memToReg);
    checkAddrSel("reset memAddrSel", memAddrSel_t'(0), memAddrSel);
    checkSize("reset storeSize", accessSize_t'(0), storeSize);
    checkSize("reset loadSize", accessSize_t'(0), loadSize);
    reset  = 1'b0;
    waited = 0;
    while (!pcWrite && waited < cycleLimit) begin
        @(posedge clk);
        #1;
        waited++;
        checkEnable("fetch irWrite early", 1'b0, irWrite);
        checkEnable("fetch other writes", 1'b0, |{memWrite, regWrite, epcWrite});
    end
    if (!pcWrite) reportProblem("fetch: no pcWrite after reset");
    checkPcSource("fetch pcSource", pcFromAlu, pcSource);
    checkAluSrc("fetch aluSrcA", srcAPc, aluSrcA);
    checkAluSrc("fetch aluSrcB", srcBFour, aluSrcB); // PC plus four
    checkAluOp("fetch aluOp", aluAdd, aluOp);
    @(posedge clk);
    #1;
    checkEnable("fetch irWrite", 1'b1, irWrite);
    checkEnable("fetch pcWrite width", 1'b0, pcWrite);
endtask

task automatic testAlu(input string name, input opcode_t op, input funct_t fn,
                       input logic ovf, input int expLen, input regDst_t expDst,
                       input memToReg_t expSrc, input aluOp_t expOp, input logic opUsed);
    runInstr(name, op, fn, ovf, 1'b0, 1'b0);
    checkLength({name, " length"}, expLen, cycles);
    checkCount({name, " regWrite pulses"}, 1, regPulses);
    checkRegDst({name, " regDst"}, expDst, wrDst);
    checkMemToReg({name, " memToReg"}, expSrc, wrSrc);
    if (opUsed) checkAluOp({name, " aluOp"}, expOp, wrOp);
    checkCount({name, " epcWrite pulses"}, 0, epcPulses);
endtask

task automatic testException(input string name, input opcode_t op, input funct_t fn,
                             input logic ovf, input int expLen, input memAddrSel_t expAddr);
    runInstr(name, op, fn, ovf, 1'b0, 1'b0);
    checkLength({name, " length"}, expLen, cycles);
    checkCount({name, " regWrite pulses"}, 0, regPulses);
    checkCount({name, " epcWrite pulses"}, 1, epcPulses);
    checkCount({name, " pcWrite pulses"}, 2, pcPulses); // Handler jump, then next fetch
    checkPcSource({name, " pcSource"}, pcFromException, jumpSrc);
    checkAddrSel({name, " memAddrSel"}, expAddr, jumpAddr);
    checkSize({name, " loadSize"}, sizeByte, jumpLoad);
endtask

task automatic testBranch(input string name, input opcode_t op);
    logic [31:0] drawn;
    logic        taken;
    drawn = $random(seed);
    taken = branchHolds(op, drawn[0], drawn[1]);
    runInstr(name, op, noFunct, 1'b0, drawn[0], drawn[1]);
    checkLength({name, " length"}, 8, cycles);
    checkCount({name, " pcWrite pulses"}, taken ? 2 : 1, pcPulses);
    if (taken) checkPcSource({name, " pcSource"}, pcFromAluOut, jumpSrc);
    checkCount({name, " regWrite pulses"}, 0, regPulses);
endtask

task automatic testMemory(input string name, input opcode_t op, input logic store,
                          input accessSize_t size);
    runInstr(name, op, noFunct, 1'b0, 1'b0, 1'b0);
    checkLength({name, " length"}, 9 + waitCycles, cycles);
    checkCount({name, " memWrite pulses"}, store ? 1 : 0, memPulses);
    checkCount({name, " regWrite pulses"}, store ? 0 : 1, regPulses);
    if (store) begin
        checkSize({name, " storeSize"}, size, stSize);
    end else begin
        checkMemToReg({name, " memToReg"}, wbMemData, wrSrc);
        checkRegDst({name, " regDst"}, dstRt, wrDst);
        checkSize({name, " loadSize"}, size, wrLoad);
    end
endtask

task automatic testJump(input string name, input opcode_t op, input funct_t fn,
                        input int expLen, input pcSource_t expSrc, input logic link);
    runInstr(name, op, fn, 1'b0, 1'b0, 1'b0);
    checkLength({name, " length"}, expLen, cycles);
    checkCount({name, " pcWrite pulses"}, 2, pcPulses);
    checkPcSource({name, " pcSource"}, expSrc, jumpSrc);
    checkCount({name, " regWrite pulses"}, link ? 1 : 0, regPulses);
    if (link) begin
        checkRegDst({name, " regDst"}, dstRa, wrDst);
        checkEnable({name, " link before jump"}, 1'b1, firstRegCycle < firstPcCycle);
    end
endtask

//--- tb/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;
    import controlPkg::*;

    localparam int waitCycles = 2;  // memWaitCycles default of the DUT
    localparam int numInstr   = 32;
    localparam int cycleLimit = 20; // Per instruction, well above the longest

    logic        clk = 1'b0;
    logic        reset;
    opcode_t     opcode;
    funct_t      funct;
    logic        overflow;
    logic        equal;
    logic        greater;
    logic        memWrite;
    logic        pcWrite;
    logic        irWrite;
    logic        regWrite;
    logic        abWrite;
    logic        aluOutWrite;
    logic        epcWrite;
    aluOp_t      aluOp;
    aluSrc_t     aluSrcA;
    aluSrc_t     aluSrcB;
    pcSource_t   pcSource;
    regDst_t     regDst;
    memToReg_t   memToReg;
    memAddrSel_t memAddrSel;
    accessSize_t storeSize;
    accessSize_t loadSize;

    int     checks      = 0;
    int     valueErrors = 0;
    int     otherErrors = 0;
    integer seed        = 32'h61c1;

    controlUnit dut (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .funct      (funct),
        .overflow   (overflow),
        .equal      (equal),
        .greater    (greater),
        .memWrite   (memWrite),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .abWrite    (abWrite),
        .aluOutWrite(aluOutWrite),
        .epcWrite   (epcWrite),
        .aluOp      (aluOp),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .pcSource   (pcSource),
        .regDst     (regDst),
        .memToReg   (memToReg),
        .memAddrSel (memAddrSel),
        .storeSize  (storeSize),
        .loadSize   (loadSize)
    );

    always #5 clk = ~clk;

    `include "controlTbTasks.svh"

    // Longest instruction is 13 cycles
    initial begin
        #(numInstr * 13 * 10 + 200);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        driveInputs(opRFormat, fnAdd, 1'b0, 1'b0, 1'b0);
        testResetFetch();
        testAlu("add", opRFormat, fnAdd, 1'b0, 8, dstRd, wbAluOut, aluAdd, 1'b1);
        testAlu("sub", opRFormat, fnSub, 1'b0, 8, dstRd, wbAluOut, aluSub, 1'b1);
        testAlu("and", opRFormat, fnAnd, 1'b0, 8, dstRd, wbAluOut, aluAnd, 1'b1);
        testAlu("slt", opRFormat, fnSlt, 1'b0, 7, dstRd, wbCompare, aluCompare, 1'b1);
        testAlu("addi", opAddi, noFunct, 1'b0, 8, dstRt, wbAluOut, aluAdd, 1'b1);
        testAlu("addiu", opAddiu, noFunct, 1'b0, 8, dstRt, wbAluOut, aluAdd, 1'b1);
        testAlu("slti", opSlti, noFunct, 1'b0, 7, dstRt, wbCompare, aluCompare, 1'b1);
        testAlu("lui", opLui, noFunct, 1'b0, 7, dstRt, wbUpperImm, aluPass, 1'b0);
        testAlu("and ovf", opRFormat, fnAnd, 1'b1, 8, dstRd, wbAluOut, aluAnd, 1'b1);
        testAlu("addiu ovf", opAddiu, noFunct, 1'b1, 8, dstRt, wbAluOut, aluAdd, 1'b1);
        testException("add ovf", opRFormat, fnAdd, 1'b1, 11 + waitCycles, addrOverflowVector);
        testException("sub ovf", opRFormat, fnSub, 1'b1, 11 + waitCycles, addrOverflowVector);
        testException("addi ovf", opAddi, noFunct, 1'b1, 11 + waitCycles, addrOverflowVector);
        repeat (2) begin
            testBranch("beq", opBeq);
            testBranch("bne", opBne);
            testBranch("ble", opBle);
            testBranch("bgt", opBgt);
        end
        testMemory("sw", opSw, 1'b1, sizeWord);
        testMemory("sh", opSh, 1'b1, sizeHalf);
        testMemory("sb", opSb, 1'b1, sizeByte);
        testMemory("lw", opLw, 1'b0, sizeWord);
        testMemory("lh", opLh, 1'b0, sizeHalf);
        testMemory("lb", opLb, 1'b0, sizeByte);
        testJump("j", opJ, noFunct, 7, pcFromJump, 1'b0);
        testJump("jr", opRFormat, fnJr, 7, pcFromAlu, 1'b0); // Register A through the ALU
        testJump("jal", opJal, noFunct, 9, pcFromJump, 1'b1);
        testException("bad opcode", opcode_t'(6'h3F), noFunct, 1'b0, 10 + waitCycles,
                      addrInvalidVector);
        testException("bad funct", opRFormat, funct_t'(6'h3F), 1'b0, 10 + waitCycles,
                      addrInvalidVector);
        $display("Checks run: %0d, value errors: %0d, other errors: %0d",
                 checks, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
